// File: verilog.f
hdl/axi_lite_pkg.sv
hdl/cmp_pkg.sv
hdl/stream_fork.sv
hdl/chan_compare.sv
hdl/bus_compare.sv
hdl/subordinate_compare.sv
hdl/ref_mem_subordinate.sv
hdl/compare_top.sv
tb/tb_compare_top.sv

// File: tb/tb_compare_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Plays the manager and an in-order test subordinate with one fault per row
// b_ready and r_ready stay high, so manager back-pressure is not exercised
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_compare_top;

    import axi_lite_pkg::*;
    import cmp_pkg::*;

    localparam int TIMEOUT = 200;

    typedef enum logic [1:0] {F_NONE, F_RDATA, F_BRESP, F_BID} fault_e;

    // One scenario, names live in a parallel queue
    typedef struct packed {
        logic              is_write;
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        fault_e            fault;
        resp_e             exp_resp;
        logic [DATA_W-1:0] exp_data;
        mismatch_t         exp_mis;
    } row_t;

    logic      clk_i;
    logic      rst_n_i;
    bus_req_t  mgr_req;
    bus_rsp_t  mgr_rsp;
    bus_req_t  test_req;
    bus_rsp_t  test_rsp = '0;
    mismatch_t mismatch;
    logic      busy;

    // Test subordinate state
    logic [DATA_W-1:0] tmem [256];
    aw_chan_t          aw_q;
    w_chan_t           w_q;
    logic              have_aw;
    logic              have_w;
    int                aw_wait;
    int                w_wait;
    int                ar_wait;
    fault_e            cur_fault = F_NONE;
    logic [15:0]       lfsr = 16'd9076;

    row_t      rows [$];
    string     names [$];
    mismatch_t mis_acc;
    int        pass_count = 0;
    int        fail_count = 0;
    int        error_count = 0;
    bit        timed_out = 1'b0;

    compare_top #(.FIFO_DEPTH(4), .MEM_WORDS(256)) u_dut (
        .clk_i, .rst_n_i,
        .mgr_req_i(mgr_req), .mgr_rsp_o(mgr_rsp),
        .test_req_o(test_req), .test_rsp_i(test_rsp),
        .mismatch_o(mismatch), .busy_o(busy)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Stall of 0 to 3 cycles, two LFSR bits
    task automatic next_delay(output int d);
        d = 0;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            d = d | (int'(lfsr[0]) << b);
        end
    endtask

    // Test subordinate: same memory rules as the reference, plus the row's fault
    always @(posedge clk_i or negedge rst_n_i) begin : test_sub
        int   d;
        logic in_range;
        if (!rst_n_i) begin
            test_rsp <= '0;
            have_aw  <= 1'b0;
            have_w   <= 1'b0;
            aw_wait  <= 0;
            w_wait   <= 0;
            ar_wait  <= 0;
            for (int i = 0; i < 256; i++) begin
                tmem[i] <= '0;
            end
        end else begin
            // AW and W, each after its own stall
            if (test_req.aw_valid && test_rsp.aw_ready) begin
                aw_q              <= test_req.aw;
                have_aw           <= 1'b1;
                test_rsp.aw_ready <= 1'b0;
                next_delay(d);
                aw_wait           <= d;
            end else if (test_req.aw_valid && !have_aw && !test_rsp.b_valid) begin
                if (aw_wait == 0) test_rsp.aw_ready <= 1'b1;
                else aw_wait <= aw_wait - 1;
            end
            if (test_req.w_valid && test_rsp.w_ready) begin
                w_q              <= test_req.w;
                have_w           <= 1'b1;
                test_rsp.w_ready <= 1'b0;
                next_delay(d);
                w_wait           <= d;
            end else if (test_req.w_valid && !have_w && !test_rsp.b_valid) begin
                if (w_wait == 0) test_rsp.w_ready <= 1'b1;
                else w_wait <= w_wait - 1;
            end
            // Write and answer once both halves are in
            if (test_rsp.b_valid && test_req.b_ready) begin
                test_rsp.b_valid <= 1'b0;
            end else if (have_aw && have_w && !test_rsp.b_valid) begin
                in_range = (aw_q.addr < 16'h0400);
                for (int l = 0; l < STRB_W; l++) begin
                    if (in_range && w_q.strb[l]) begin
                        tmem[aw_q.addr[9:2]][8*l +: 8] <= w_q.data[8*l +: 8];
                    end
                end
                test_rsp.b.id    <= (cur_fault == F_BID) ? aw_q.id ^ 2'd1 : aw_q.id;
                test_rsp.b.resp  <= (!in_range || cur_fault == F_BRESP) ? SLVERR : OKAY;
                test_rsp.b_valid <= 1'b1;
                have_aw          <= 1'b0;
                have_w           <= 1'b0;
            end
            // Read, R clears first so a new beat can follow
            if (test_rsp.r_valid && test_req.r_ready) begin
                test_rsp.r_valid <= 1'b0;
            end
            if (test_req.ar_valid && test_rsp.ar_ready) begin
                in_range          = (test_req.ar.addr < 16'h0400);
                test_rsp.ar_ready <= 1'b0;
                test_rsp.r.id     <= test_req.ar.id;
                test_rsp.r.data   <= (in_range ? tmem[test_req.ar.addr[9:2]] : '0)
                                     ^ DATA_W'(cur_fault == F_RDATA);
                test_rsp.r.resp   <= in_range ? OKAY : SLVERR;
                test_rsp.r_valid  <= 1'b1;
                next_delay(d);
                ar_wait           <= d;
            end else if (test_req.ar_valid && !test_rsp.r_valid) begin
                if (ar_wait == 0) test_rsp.ar_ready <= 1'b1;
                else ar_wait <= ar_wait - 1;
            end
        end
    end

    // One clock step, collecting mismatch pulses
    task automatic tick();
        @(posedge clk_i);
        mis_acc = mis_acc | mismatch;
    endtask

    task automatic check_equal(input string name, input string what, input logic [63:0] exp,
                               input logic [63:0] act, inout bit ok);
        assert (act === exp) else begin
            $display("[ERROR] %s %s expected 0x%0h actual 0x%0h", name, what, exp, act);
            error_count++;
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic add_row(input string name, input logic is_write, input int id,
                           input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input fault_e fault, input resp_e exp_resp,
                           input logic [31:0] exp_data, input logic [3:0] exp_b,
                           input logic [3:0] exp_r);
        row_t r;
        r.is_write        = is_write;
        r.id              = id[ID_W-1:0];
        r.addr            = addr;
        r.data            = data;
        r.strb            = strb;
        r.fault           = fault;
        r.exp_resp        = exp_resp;
        r.exp_data        = exp_data;
        r.exp_mis         = '0;
        r.exp_mis.b       = exp_b;
        r.exp_mis.r       = exp_r;
        r.exp_mis.general = |{exp_b, exp_r};
        rows.push_back(r);
        names.push_back(name);
    endtask

    // Expected data follows the byte-lane rule on a memory that starts at zero
    task automatic build_table();
        add_row("wr_full", 1, 0, 16'h0010, 32'hA5A5_1234, 4'hF, F_NONE, OKAY, 0, 0, 0);
        add_row("rd_full", 0, 1, 16'h0010, 0, 0, F_NONE, OKAY, 32'hA5A5_1234, 0, 0);
        add_row("wr_part", 1, 2, 16'h0010, 32'hFFEE_DDCC, 4'b0101, F_NONE, OKAY, 0, 0, 0);
        add_row("rd_part", 0, 3, 16'h0010, 0, 0, F_NONE, OKAY, 32'hA5EE_12CC, 0, 0);
        add_row("wr_oor", 1, 1, 16'h0400, 32'hDEAD_BEEF, 4'hF, F_NONE, SLVERR, 0, 0, 0);
        add_row("rd_oor", 0, 0, 16'h0400, 0, 0, F_NONE, SLVERR, 0, 0, 0);
        add_row("rd_alias", 0, 2, 16'h0000, 0, 0, F_NONE, OKAY, 0, 0, 0);
        add_row("rd_flip", 0, 2, 16'h0010, 0, 0, F_RDATA, OKAY, 32'hA5EE_12CC, 0, 4'b0100);
        add_row("wr_slverr", 1, 3, 16'h0020, 32'h0000_00FF, 4'hF, F_BRESP, OKAY, 0, 4'b1000, 0);
        add_row("wr_bad_id", 1, 1, 16'h0024, 32'h1111_2222, 4'b1100, F_BID, OKAY, 0, 4'b0010, 0);
        add_row("rd_after", 0, 0, 16'h0020, 0, 0, F_NONE, OKAY, 32'h0000_00FF, 0, 0);
        add_row("rd_upper", 0, 3, 16'h0024, 0, 0, F_NONE, OKAY, 32'h1111_0000, 0, 0);
        add_row("rd_oor_top", 0, 1, 16'hFFFC, 0, 0, F_NONE, SLVERR, 0, 0, 0);
    endtask

    task automatic run_row(input int i);
        row_t              r;
        resp_e             got_resp;
        logic [ID_W-1:0]   got_id;
        logic [DATA_W-1:0] got_data;
        bit                aw_pend;
        bit                w_pend;
        bit                ar_pend;
        bit                rsp_pend;
        bit                ok;
        int                cnt;
        r        = rows[i];
        ok       = 1'b1;
        got_resp = OKAY;
        got_id   = '0;
        got_data = '0;
        aw_pend  = r.is_write;
        w_pend   = r.is_write;
        ar_pend  = !r.is_write;
        rsp_pend = 1'b1;
        mis_acc  = '0;
        tick();
        cur_fault        <= r.fault;
        mgr_req.aw.id    <= r.id;
        mgr_req.aw.addr  <= r.addr;
        mgr_req.ar.id    <= r.id;
        mgr_req.ar.addr  <= r.addr;
        mgr_req.w.data   <= r.data;
        mgr_req.w.strb   <= r.strb;
        mgr_req.aw_valid <= r.is_write;
        mgr_req.w_valid  <= r.is_write;
        mgr_req.ar_valid <= !r.is_write;
        // Requests drop one by one, then the reference response arrives
        cnt = 0;
        while ((aw_pend || w_pend || ar_pend || rsp_pend) && cnt < TIMEOUT) begin
            tick();
            cnt++;
            if (aw_pend && mgr_rsp.aw_ready) begin
                aw_pend = 1'b0;
                mgr_req.aw_valid <= 1'b0;
            end
            if (w_pend && mgr_rsp.w_ready) begin
                w_pend = 1'b0;
                mgr_req.w_valid <= 1'b0;
            end
            if (ar_pend && mgr_rsp.ar_ready) begin
                ar_pend = 1'b0;
                mgr_req.ar_valid <= 1'b0;
            end
            if (rsp_pend && r.is_write && mgr_rsp.b_valid) begin
                rsp_pend = 1'b0;
                got_resp = mgr_rsp.b.resp;
                got_id   = mgr_rsp.b.id;
            end
            if (rsp_pend && !r.is_write && mgr_rsp.r_valid) begin
                rsp_pend = 1'b0;
                got_resp = mgr_rsp.r.resp;
                got_id   = mgr_rsp.r.id;
                got_data = mgr_rsp.r.data;
            end
        end
        if (rsp_pend) begin
            $display("Timed out waiting for the manager response in %s", names[i]);
            timed_out = 1'b1;
            fail_count++;
            return;
        end
        // The comparator drains once the test side has answered too
        cnt = 0;
        do begin
            tick();
            cnt++;
        end while (busy && cnt < TIMEOUT);
        if (busy) begin
            $display("Timed out waiting for the comparator to go idle in %s", names[i]);
            timed_out = 1'b1;
            fail_count++;
            return;
        end
        check_equal(names[i], "resp", 64'(r.exp_resp), 64'(got_resp), ok);
        check_equal(names[i], "id", 64'(r.id), 64'(got_id), ok);
        if (!r.is_write) begin
            check_equal(names[i], "rdata", 64'(r.exp_data), 64'(got_data), ok);
        end
        check_equal(names[i], "mismatch", 64'(r.exp_mis), 64'(mis_acc), ok);
        report_test(names[i], ok);
    endtask

    initial begin
        bit ok;
        rst_n_i         = 1'b0;
        mgr_req         = '0;
        mgr_req.b_ready = 1'b1;
        mgr_req.r_ready = 1'b1;
        mis_acc         = '0;
        build_table();
        repeat (5) @(posedge clk_i);
        rst_n_i <= 1'b1;
        tick();
        tick();
        // Nothing in flight right after reset, on either side
        ok = 1'b1;
        check_equal("reset_idle", "busy", 0, 64'(busy), ok);
        check_equal("reset_idle", "mismatch", 0, 64'(mismatch), ok);
        check_equal("reset_idle", "valids", 0, 64'({mgr_rsp.b_valid, mgr_rsp.r_valid}), ok);
        check_equal("reset_idle", "test_valids", 0,
                    64'({test_req.aw_valid, test_req.w_valid, test_req.ar_valid}), ok);
        report_test("reset_idle", ok);
        // Back-to-back rows under random test-side stalls
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
            if (timed_out) break;
        end
        if (!timed_out) begin
            ok = 1'b1;
            tick();
            check_equal("final_idle", "busy", 0, 64'(busy), ok);
            report_test("final_idle", ok);
        end
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (fail_count == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: hdl/compare_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Test subordinate is external and must answer in order
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module compare_top #(
    parameter int unsigned FIFO_DEPTH = cmp_pkg::FIFO_DEPTH_DEF,
    parameter int unsigned MEM_WORDS  = 256
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  axi_lite_pkg::bus_req_t mgr_req_i,
    output axi_lite_pkg::bus_rsp_t mgr_rsp_o,
    output axi_lite_pkg::bus_req_t test_req_o,
    input  axi_lite_pkg::bus_rsp_t test_rsp_i,
    output cmp_pkg::mismatch_t     mismatch_o,
    output logic                   busy_o
);

    import axi_lite_pkg::*;

    // Internal reference bus
    bus_req_t ref_req;
    bus_rsp_t ref_rsp;

    subordinate_compare #(.FIFO_DEPTH(FIFO_DEPTH)) u_sub_compare (
        .clk_i,
        .rst_n_i,
        .mgr_req_i,
        .mgr_rsp_o,
        .ref_req_o  (ref_req),
        .ref_rsp_i  (ref_rsp),
        .test_req_o,
        .test_rsp_i,
        .mismatch_o,
        .busy_o
    );

    ref_mem_subordinate #(.MEM_WORDS(MEM_WORDS)) u_ref_mem (
        .clk_i,
        .rst_n_i,
        .req_i (ref_req),
        .rsp_o (ref_rsp)
    );

endmodule

// File: hdl/ref_mem_subordinate.sv
// ~~~~~~~~~~~~~~~~~~~~
// One write and one read in flight; addresses at MEM_WORDS*4 and up give SLVERR
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ref_mem_subordinate #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  axi_lite_pkg::bus_req_t req_i,
    output axi_lite_pkg::bus_rsp_t rsp_o
);

    import axi_lite_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_WAIT_DATA,
        W_RESP
    } mem_state_e;

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam logic [ADDR_W-1:0] ADDR_LIMIT = ADDR_W'(MEM_WORDS * 4);

    mem_state_e        state_q, state_d;
    logic [DATA_W-1:0] mem_q [MEM_WORDS];
    aw_chan_t          aw_q;
    b_chan_t           b_q;
    r_chan_t           r_q;
    logic              r_valid_q;
    logic              aw_fire, w_fire, ar_fire;
    logic              wr_ok, rd_ok;
    logic [IDX_W-1:0]  wr_idx, rd_idx;

    // Handshakes
    assign aw_fire = req_i.aw_valid && rsp_o.aw_ready;
    assign w_fire  = req_i.w_valid && rsp_o.w_ready;
    assign ar_fire = req_i.ar_valid && rsp_o.ar_ready;

    // Word index from bits IDX_W+1:2
    assign wr_ok  = (aw_q.addr < ADDR_LIMIT);
    assign rd_ok  = (req_i.ar.addr < ADDR_LIMIT);
    assign wr_idx = aw_q.addr[IDX_W+1:2];
    assign rd_idx = req_i.ar.addr[IDX_W+1:2];

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            W_IDLE:      if (aw_fire) state_d = W_WAIT_DATA;
            W_WAIT_DATA: if (w_fire) state_d = W_RESP;
            W_RESP:      if (req_i.b_ready) state_d = W_IDLE;
            default:     state_d = W_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= W_IDLE;
            r_valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Read response pending until r_ready
            if (ar_fire) begin
                r_valid_q <= 1'b1;
            end else if (req_i.r_ready) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // Request and response payloads
    always_ff @(posedge clk_i) begin
        if (aw_fire) begin
            aw_q <= req_i.aw;
        end
        if (w_fire) begin
            b_q.id   <= aw_q.id;
            b_q.resp <= wr_ok ? OKAY : SLVERR;
        end
        if (ar_fire) begin
            r_q.id   <= req_i.ar.id;
            r_q.data <= rd_ok ? mem_q[rd_idx] : '0;
            r_q.resp <= rd_ok ? OKAY : SLVERR;
        end
    end

    // Memory starts cleared, out of range writes dropped
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_q[i] <= '0;
            end
        end else if (w_fire && wr_ok) begin
            for (int l = 0; l < STRB_W; l++) begin
                if (req_i.w.strb[l]) begin
                    mem_q[wr_idx][8*l +: 8] <= req_i.w.data[8*l +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp_o          = '0;
        rsp_o.aw_ready = (state_q == W_IDLE);
        rsp_o.w_ready  = (state_q == W_WAIT_DATA);
        rsp_o.b_valid  = (state_q == W_RESP);
        rsp_o.b        = b_q;
        rsp_o.ar_ready = !r_valid_q;
        rsp_o.r_valid  = r_valid_q;
        rsp_o.r        = r_q;
    end

    // B holds with a fixed payload until the manager takes it
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_o.b_valid && !req_i.b_ready |=> rsp_o.b_valid && $stable(rsp_o.b))
        else $error("B response changed before b_ready");

endmodule

// File: hdl/subordinate_compare.sv
// ~~~~~~~~~~~~~~~~~~~~
// Manager sees only reference responses; test responses are always accepted
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module subordinate_compare #(
    parameter int unsigned FIFO_DEPTH = cmp_pkg::FIFO_DEPTH_DEF
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  axi_lite_pkg::bus_req_t mgr_req_i,
    output axi_lite_pkg::bus_rsp_t mgr_rsp_o,
    output axi_lite_pkg::bus_req_t ref_req_o,
    input  axi_lite_pkg::bus_rsp_t ref_rsp_i,
    output axi_lite_pkg::bus_req_t test_req_o,
    input  axi_lite_pkg::bus_rsp_t test_rsp_i,
    output cmp_pkg::mismatch_t     mismatch_o,
    output logic                   busy_o
);

    import axi_lite_pkg::*;

    // Bus towards the comparator, after the forks
    bus_req_t   ref_req_in, test_req_in;
    bus_rsp_t   ref_rsp_in, test_rsp_in;
    // Fork outputs, bit 0 reference and bit 1 test
    logic [1:0] aw_valid, aw_ready;
    logic [1:0] w_valid, w_ready;
    logic [1:0] ar_valid, ar_ready;
    logic       aw_ready_mgr, w_ready_mgr, ar_ready_mgr;

    assign aw_ready = {test_rsp_in.aw_ready, ref_rsp_in.aw_ready};
    assign w_ready  = {test_rsp_in.w_ready, ref_rsp_in.w_ready};
    assign ar_ready = {test_rsp_in.ar_ready, ref_rsp_in.ar_ready};

    stream_fork #(.N_OUP(2)) u_fork_aw (
        .clk_i, .rst_n_i,
        .valid_i(mgr_req_i.aw_valid), .ready_o(aw_ready_mgr),
        .valid_o(aw_valid), .ready_i(aw_ready)
    );

    stream_fork #(.N_OUP(2)) u_fork_w (
        .clk_i, .rst_n_i,
        .valid_i(mgr_req_i.w_valid), .ready_o(w_ready_mgr),
        .valid_o(w_valid), .ready_i(w_ready)
    );

    stream_fork #(.N_OUP(2)) u_fork_ar (
        .clk_i, .rst_n_i,
        .valid_i(mgr_req_i.ar_valid), .ready_o(ar_ready_mgr),
        .valid_o(ar_valid), .ready_i(ar_ready)
    );

    always_comb begin
        // Same payloads on both sides, valids from the forks
        ref_req_in           = mgr_req_i;
        test_req_in          = mgr_req_i;
        ref_req_in.aw_valid  = aw_valid[0];
        ref_req_in.w_valid   = w_valid[0];
        ref_req_in.ar_valid  = ar_valid[0];
        test_req_in.aw_valid = aw_valid[1];
        test_req_in.w_valid  = w_valid[1];
        test_req_in.ar_valid = ar_valid[1];
        // Test responses are drained here
        test_req_in.b_ready  = 1'b1;
        test_req_in.r_ready  = 1'b1;
        // Reference response with the fork readies
        mgr_rsp_o            = ref_rsp_in;
        mgr_rsp_o.aw_ready   = aw_ready_mgr;
        mgr_rsp_o.w_ready    = w_ready_mgr;
        mgr_rsp_o.ar_ready   = ar_ready_mgr;
    end

    bus_compare #(.FIFO_DEPTH(FIFO_DEPTH)) u_bus_compare (
        .clk_i, .rst_n_i,
        .ref_req_i(ref_req_in), .test_req_i(test_req_in),
        .ref_rsp_o(ref_rsp_in), .test_rsp_o(test_rsp_in),
        .ref_req_o, .test_req_o,
        .ref_rsp_i, .test_rsp_i,
        .mismatch_o, .busy_o
    );

endmodule

// File: hdl/bus_compare.sv
// ~~~~~~~~~~~~~~~~~~~~
// Side 0 is the reference, side 1 the test; a full FIFO stalls its channel
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module bus_compare #(
    parameter int unsigned FIFO_DEPTH = cmp_pkg::FIFO_DEPTH_DEF
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  axi_lite_pkg::bus_req_t ref_req_i,
    input  axi_lite_pkg::bus_req_t test_req_i,
    output axi_lite_pkg::bus_rsp_t ref_rsp_o,
    output axi_lite_pkg::bus_rsp_t test_rsp_o,
    output axi_lite_pkg::bus_req_t ref_req_o,
    output axi_lite_pkg::bus_req_t test_req_o,
    input  axi_lite_pkg::bus_rsp_t ref_rsp_i,
    input  axi_lite_pkg::bus_rsp_t test_rsp_i,
    output cmp_pkg::mismatch_t     mismatch_o,
    output logic                   busy_o
);

    import axi_lite_pkg::*;
    import cmp_pkg::*;

    bus_req_t   req_in  [2];
    bus_req_t   req_out [2];
    bus_rsp_t   rsp_in  [2];
    bus_rsp_t   rsp_out [2];
    logic [1:0] aw_full, w_full, ar_full, b_full, r_full;
    logic [1:0] aw_push, w_push, ar_push, b_push, r_push;
    logic [4:0] busy;
    id_vec_t    aw_mis, w_mis, b_mis, ar_mis, r_mis;

    assign req_in[0]  = ref_req_i;
    assign req_in[1]  = test_req_i;
    assign rsp_in[0]  = ref_rsp_i;
    assign rsp_in[1]  = test_rsp_i;
    assign ref_req_o  = req_out[0];
    assign test_req_o = req_out[1];
    assign ref_rsp_o  = rsp_out[0];
    assign test_rsp_o = rsp_out[1];

    for (genvar s = 0; s < 2; s++) begin : g_side
        always_comb begin
            req_out[s] = req_in[s];
            rsp_out[s] = rsp_in[s];
            // Requests toward the subordinate
            req_out[s].aw_valid = req_in[s].aw_valid && !aw_full[s];
            req_out[s].w_valid  = req_in[s].w_valid && !w_full[s];
            req_out[s].ar_valid = req_in[s].ar_valid && !ar_full[s];
            rsp_out[s].aw_ready = rsp_in[s].aw_ready && !aw_full[s];
            rsp_out[s].w_ready  = rsp_in[s].w_ready && !w_full[s];
            rsp_out[s].ar_ready = rsp_in[s].ar_ready && !ar_full[s];
            // Responses toward the manager or the tie-off
            rsp_out[s].b_valid  = rsp_in[s].b_valid && !b_full[s];
            rsp_out[s].r_valid  = rsp_in[s].r_valid && !r_full[s];
            req_out[s].b_ready  = req_in[s].b_ready && !b_full[s];
            req_out[s].r_ready  = req_in[s].r_ready && !r_full[s];
        end

        // Record a beat on every handshake
        assign aw_push[s] = req_out[s].aw_valid && rsp_in[s].aw_ready;
        assign w_push[s]  = req_out[s].w_valid && rsp_in[s].w_ready;
        assign ar_push[s] = req_out[s].ar_valid && rsp_in[s].ar_ready;
        assign b_push[s]  = rsp_out[s].b_valid && req_in[s].b_ready;
        assign r_push[s]  = rsp_out[s].r_valid && req_in[s].r_ready;
    end

    chan_compare #(.payload_t(aw_chan_t), .DEPTH(FIFO_DEPTH), .HAS_ID(1'b1)) u_cmp_aw (
        .clk_i, .rst_n_i,
        .ref_push_i(aw_push[0]), .ref_data_i(req_in[0].aw),
        .test_push_i(aw_push[1]), .test_data_i(req_in[1].aw),
        .ref_full_o(aw_full[0]), .test_full_o(aw_full[1]),
        .mismatch_o(aw_mis), .busy_o(busy[0])
    );

    chan_compare #(.payload_t(w_chan_t), .DEPTH(FIFO_DEPTH), .HAS_ID(1'b0)) u_cmp_w (
        .clk_i, .rst_n_i,
        .ref_push_i(w_push[0]), .ref_data_i(req_in[0].w),
        .test_push_i(w_push[1]), .test_data_i(req_in[1].w),
        .ref_full_o(w_full[0]), .test_full_o(w_full[1]),
        .mismatch_o(w_mis), .busy_o(busy[1])
    );

    chan_compare #(.payload_t(b_chan_t), .DEPTH(FIFO_DEPTH), .HAS_ID(1'b1)) u_cmp_b (
        .clk_i, .rst_n_i,
        .ref_push_i(b_push[0]), .ref_data_i(rsp_in[0].b),
        .test_push_i(b_push[1]), .test_data_i(rsp_in[1].b),
        .ref_full_o(b_full[0]), .test_full_o(b_full[1]),
        .mismatch_o(b_mis), .busy_o(busy[2])
    );

    chan_compare #(.payload_t(ar_chan_t), .DEPTH(FIFO_DEPTH), .HAS_ID(1'b1)) u_cmp_ar (
        .clk_i, .rst_n_i,
        .ref_push_i(ar_push[0]), .ref_data_i(req_in[0].ar),
        .test_push_i(ar_push[1]), .test_data_i(req_in[1].ar),
        .ref_full_o(ar_full[0]), .test_full_o(ar_full[1]),
        .mismatch_o(ar_mis), .busy_o(busy[3])
    );

    chan_compare #(.payload_t(r_chan_t), .DEPTH(FIFO_DEPTH), .HAS_ID(1'b1)) u_cmp_r (
        .clk_i, .rst_n_i,
        .ref_push_i(r_push[0]), .ref_data_i(rsp_in[0].r),
        .test_push_i(r_push[1]), .test_data_i(rsp_in[1].r),
        .ref_full_o(r_full[0]), .test_full_o(r_full[1]),
        .mismatch_o(r_mis), .busy_o(busy[4])
    );

    // W only ever sets bit 0
    always_comb begin
        mismatch_o.aw      = aw_mis;
        mismatch_o.w       = |w_mis;
        mismatch_o.b       = b_mis;
        mismatch_o.ar      = ar_mis;
        mismatch_o.r       = r_mis;
        mismatch_o.general = |{aw_mis, w_mis, b_mis, ar_mis, r_mis};
    end

    assign busy_o = |busy;

endmodule

// File: hdl/chan_compare.sv
// ~~~~~~~~~~~~~~~~~~~~
// Beats are paired strictly in order; the caller must not push when full
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module chan_compare #(
    parameter type         payload_t = axi_lite_pkg::aw_chan_t,
    parameter int unsigned DEPTH     = cmp_pkg::FIFO_DEPTH_DEF,
    parameter bit          HAS_ID    = 1'b1
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            ref_push_i,
    input  payload_t        ref_data_i,
    input  logic            test_push_i,
    input  payload_t        test_data_i,
    output logic            ref_full_o,
    output logic            test_full_o,
    output cmp_pkg::id_vec_t mismatch_o,
    output logic            busy_o
);

    import axi_lite_pkg::*;
    import cmp_pkg::*;

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    // Index 0 is the reference side, index 1 the test side
    payload_t        mem_q     [2][DEPTH];
    payload_t        push_data [2];
    payload_t        head      [2];
    logic [PW-1:0]   wr_ptr_q  [2];
    logic [PW-1:0]   rd_ptr_q  [2];
    logic [CW-1:0]   cnt_q     [2];
    logic [1:0]      push;
    logic [1:0]      full;
    logic [1:0]      empty;
    logic            pop;
    logic [ID_W-1:0] ref_id;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push         = {test_push_i, ref_push_i};
    assign push_data[0] = ref_data_i;
    assign push_data[1] = test_data_i;

    // Pop a pair as soon as both sides hold a beat
    assign pop = !empty[0] && !empty[1];

    for (genvar s = 0; s < 2; s++) begin : g_fifo
        assign full[s]  = (cnt_q[s] == CW'(DEPTH));
        assign empty[s] = (cnt_q[s] == '0);
        assign head[s]  = mem_q[s][rd_ptr_q[s]];

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                wr_ptr_q[s] <= '0;
                rd_ptr_q[s] <= '0;
                cnt_q[s]    <= '0;
            end else begin
                if (push[s]) begin
                    wr_ptr_q[s] <= ptr_inc(wr_ptr_q[s]);
                end
                if (pop) begin
                    rd_ptr_q[s] <= ptr_inc(rd_ptr_q[s]);
                end
                cnt_q[s] <= cnt_q[s] + CW'(push[s]) - CW'(pop);
            end
        end

        // Storage only
        always_ff @(posedge clk_i) begin
            if (push[s]) begin
                mem_q[s][wr_ptr_q[s]] <= push_data[s];
            end
        end
    end

    assign ref_full_o  = full[0];
    assign test_full_o = full[1];

    // Flag index comes from the reference beat, bit 0 without an ID
    assign ref_id = HAS_ID ? head[0][$bits(payload_t)-1 -: ID_W] : '0;

    // One-cycle pulse, registered after the pop
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mismatch_o <= '0;
        end else if (pop && (head[0] != head[1])) begin
            mismatch_o <= N_ID'(1) << ref_id;
        end else begin
            mismatch_o <= '0;
        end
    end

    // Busy also covers the pulse cycle
    assign busy_o = !empty[0] || !empty[1] || (|mismatch_o);

    // Full gating lives in bus_compare
    assert property (@(posedge clk_i) disable iff (!rst_n_i) ((push & full) == '0))
        else $error("push into a full compare FIFO");

endmodule

// File: hdl/stream_fork.sv
// ~~~~~~~~~~~~~~~~~~~~
// Upstream valid must stay high until ready_o; no added latency
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stream_fork #(
    parameter int unsigned N_OUP = 2
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    output logic             ready_o,
    output logic [N_OUP-1:0] valid_o,
    input  logic [N_OUP-1:0] ready_i
);

    // Outputs that already took the current beat
    logic [N_OUP-1:0] done_q;
    logic [N_OUP-1:0] done_d;
    logic [N_OUP-1:0] fire;

    always_comb begin
        // Offer the beat only to outputs still pending
        valid_o = {N_OUP{valid_i}} & ~done_q;
        fire    = valid_o & ready_i;
        // Complete when the last pending output transfers
        ready_o = valid_i && (&(done_q | fire));
        // Clear the mask once the whole fork is done
        done_d  = ready_o ? '0 : (done_q | fire);
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done_q <= '0;
        end else begin
            done_q <= done_d;
        end
    end

    // A pending output keeps its valid until it transfers
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (($past(valid_o & ~ready_i) & ~valid_o) == '0))
        else $error("fork output valid dropped before transfer");

endmodule

// File: hdl/cmp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Mismatch flags are one-cycle pulses, one bit per ID
// ~~~~~~~~~~~~~~~~~~~~
package cmp_pkg;

    // One flag per possible ID
    localparam int N_ID = 2 ** axi_lite_pkg::ID_W;

    // Queue depth per channel and side
    localparam int unsigned FIFO_DEPTH_DEF = 4;

    typedef logic [N_ID-1:0] id_vec_t;

    // Mismatch report
    typedef struct packed {
        id_vec_t aw;
        logic    w;        // W has no ID
        id_vec_t b;
        id_vec_t ar;
        id_vec_t r;
        logic    general;  // OR of all the above
    } mismatch_t;

endpackage

// File: hdl/axi_lite_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Single-beat AXI subset: no bursts, no atomics, responses in order
// The ID sits in the top bits of every channel that carries one
// ~~~~~~~~~~~~~~~~~~~~
package axi_lite_pkg;

    // Bus widths
    localparam int ID_W   = 2;
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Only the codes the memory can produce
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Write address, 18 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
    } aw_chan_t;

    // Read address shares the AW layout
    typedef aw_chan_t ar_chan_t;

    // Write data, 36 bits
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_chan_t;

    // Write response, 4 bits
    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_chan_t;

    // Read data, 36 bits
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
    } r_chan_t;

    // Manager to subordinate
    typedef struct packed {
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        ar_chan_t ar;
        logic     ar_valid;
        logic     b_ready;
        logic     r_ready;
    } bus_req_t;

    // Subordinate to manager
    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        logic    ar_ready;
        b_chan_t b;
        logic    b_valid;
        r_chan_t r;
        logic    r_valid;
    } bus_rsp_t;

endpackage
